//--- project.f
+incdir+bench
src/deflate_cl_pkg.sv
src/cl_rle_ctrl_pkg.sv
src/cl_rle_fsm.sv
src/run_counter.sv
src/seq_emitter.sv
src/cl_rle_top.sv
bench/tb_clock.sv
bench/cl_rle_props.sv
bench/cl_rle_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= cl_rle_tb
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/cl_rle_model.svh
// reference encoder for the code-length alphabet
// expected symbol queues, per-table totals and typed compare tasks
`ifndef CL_RLE_MODEL_SVH
`define CL_RLE_MODEL_SVH

cl_sym_t       exp_sym_q[$];
cl_extra_t     exp_extra_q[$];
cl_extra_len_t exp_xlen_q[$];
seq_cnt_t      exp_cnt_q[$];
xtr_total_t    exp_tot_q[$];
seq_cnt_t      mdl_cnt;
xtr_total_t    mdl_tot;

task automatic push_sym(input cl_sym_t sym, input cl_extra_t extra, input cl_extra_len_t xlen);
  exp_sym_q.push_back(sym);
  exp_extra_q.push_back(extra);
  exp_xlen_q.push_back(xlen);
  mdl_cnt = mdl_cnt + 1'b1;
  mdl_tot = mdl_tot + xtr_total_t'(xlen);
endtask

// 18 covers 11..138 zeros, 17 covers 3..10
task automatic model_zero_run(input int z);
  int left;
  left = z;
  while (left >= 138)
  begin
    push_sym(5'd18, 7'd127, 3'd7);
    left = left - 138;
  end
  if (left >= 11)
    push_sym(5'd18, cl_extra_t'(left - 11), 3'd7);
  else if (left >= 3)
    push_sym(5'd17, cl_extra_t'(left - 3), 3'd3);
  else
    repeat (left) push_sym(5'd0, 7'd0, 3'd0);
endtask

task automatic model_nz_run(input cl_len_t v, input int n);
  int rpt;
  rpt = n - 1;  // first occurrence is a literal
  push_sym({1'b0, v}, 7'd0, 3'd0);
  while (rpt >= 6)
  begin
    push_sym(5'd16, 7'd3, 3'd2);
    rpt = rpt - 6;
  end
  if (rpt >= 3)
    push_sym(5'd16, cl_extra_t'(rpt - 3), 3'd2);
  else
    repeat (rpt) push_sym({1'b0, v}, 7'd0, 3'd0);
endtask

// splits cur_tbl into runs of equal values
task automatic model_table();
  int      i;
  int      n;
  cl_len_t v;
  mdl_cnt = '0;
  mdl_tot = '0;
  i = 0;
  while (i < cur_tbl.size())
  begin
    v = cur_tbl[i];
    n = 0;
    while (i < cur_tbl.size() && cur_tbl[i] == v)
    begin
      n++;
      i++;
    end
    if (v == 4'd0)
      model_zero_run(n);
    else
      model_nz_run(v, n);
  end
  exp_cnt_q.push_back(mdl_cnt);
  exp_tot_q.push_back(mdl_tot);
endtask

task automatic check_sym(input string name, input cl_sym_t got, input cl_sym_t exp);
  if (got !== exp)
    fail_now($sformatf("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
endtask

task automatic check_extra(input string name, input cl_extra_t got, input cl_extra_t exp);
  if (got !== exp)
    fail_now($sformatf("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
endtask

task automatic check_xlen(input string name, input cl_extra_len_t got,
                          input cl_extra_len_t exp);
  if (got !== exp)
    fail_now($sformatf("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
endtask

task automatic check_count(input string name, input seq_cnt_t got, input seq_cnt_t exp);
  if (got !== exp)
    fail_now($sformatf("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
endtask

task automatic check_total(input string name, input xtr_total_t got, input xtr_total_t exp);
  if (got !== exp)
    fail_now($sformatf("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
endtask

`endif

//--- bench/cl_rle_tb.sv
`timescale 1ns/1ns
// testbench for the code-length encoder
// table generation, LFSR, stall driver, output monitor and watchdog
module cl_rle_tb
  import deflate_cl_pkg::*;
  import cl_rle_ctrl_pkg::*;
();

  localparam int N_TABLES   = 10;
  localparam int MAX_LEN    = 640;
  localparam int WD_CYCLES  = N_TABLES * MAX_LEN * 8;

  logic          clk_gated;
  logic          rst_n;
  logic          cl_val;
  logic          cl_last;
  logic          out_stall;
  cl_len_t       cl_len;
  logic          busy;
  logic          seq_val;
  logic          done;
  cl_sym_t       seq_sym;
  cl_extra_t     seq_extra;
  cl_extra_len_t seq_extra_len;
  seq_cnt_t      seq_count;
  xtr_total_t    extra_total;

  logic [31:0]   lfsr_state;
  logic          stall_en;
  int            tables_done = 0;
  cl_len_t       cur_tbl[$];

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  `include "cl_rle_model.svh"

  tb_clock clk_gen (.clk(clk_gated));

  cl_rle_top dut0 (
    .clk_gated     (clk_gated),
    .rst_n         (rst_n),
    .cl_val        (cl_val),
    .cl_last       (cl_last),
    .out_stall     (out_stall),
    .cl_len        (cl_len),
    .busy          (busy),
    .seq_val       (seq_val),
    .done          (done),
    .seq_sym       (seq_sym),
    .seq_extra     (seq_extra),
    .seq_extra_len (seq_extra_len),
    .seq_count     (seq_count),
    .extra_total   (extra_total)
  );

  bind cl_rle_top cl_rle_props props0 (
    .clk_gated     (clk_gated),
    .rst_n         (rst_n),
    .busy          (busy),
    .seq_val       (seq_val),
    .out_stall     (out_stall),
    .done          (done),
    .seq_sym       (seq_sym),
    .seq_extra     (seq_extra),
    .seq_extra_len (seq_extra_len)
  );

  // fibonacci LFSR on taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          k;
    r = '0;
    for (k = 0; k < n; k++)
    begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(rand_bits(16)) % (hi - lo + 1);
  endfunction

  task automatic drive_edge();
    @(negedge clk_gated);
    if (stall_en)
      out_stall = (rand_bits(2) == 32'd0);  // about one cycle in four
    else
      out_stall = 1'b0;
  endtask

  task automatic add_run(input int v, input int len);
    repeat (len)
      if (cur_tbl.size() < MAX_LEN)
        cur_tbl.push_back(cl_len_t'(v));
  endtask

  function automatic int pick_nz(input int prev);
    int v;
    v = rand_range(1, 15);
    while (v == prev)
      v = rand_range(1, 15);
    return v;
  endfunction

  task automatic send_table();
    int   i;
    logic acc;
    i = 0;
    while (i < cur_tbl.size())
    begin
      cl_val  = 1'b1;
      cl_len  = cur_tbl[i];
      cl_last = (i == cur_tbl.size() - 1);
      @(posedge clk_gated);
      acc = !busy;  // held while busy
      drive_edge();
      if (acc)
        i++;
    end
    cl_val  = 1'b0;
    cl_last = 1'b0;
  endtask

  task automatic run_table(input logic with_stall);
    int target;
    stall_en = with_stall;
    model_table();
    target = tables_done + 1;
    send_table();
    while (tables_done < target)
      drive_edge();
    stall_en = 1'b0;
  endtask

  // symbol and done monitor
  always @(posedge clk_gated)
  begin
    cl_sym_t       e_sym;
    cl_extra_t     e_extra;
    cl_extra_len_t e_xlen;
    if (rst_n && seq_val && !out_stall)
    begin
      if (exp_sym_q.size() == 0)
        fail_now("DUT emitted a symbol that the model did not expect");
      e_sym   = exp_sym_q.pop_front();
      e_extra = exp_extra_q.pop_front();
      e_xlen  = exp_xlen_q.pop_front();
      check_sym("seq_sym", seq_sym, e_sym);
      check_extra("seq_extra", seq_extra, e_extra);
      check_xlen("seq_extra_len", seq_extra_len, e_xlen);
    end
    if (rst_n && done)
    begin
      if (exp_cnt_q.size() == 0)
        fail_now("done pulse with no table outstanding");
      if (exp_sym_q.size() != 0)
        fail_now("done pulse before all expected symbols were emitted");
      check_count("seq_count", seq_count, exp_cnt_q.pop_front());
      check_total("extra_total", extra_total, exp_tot_q.pop_front());
      tables_done++;
    end
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge clk_gated);
    fail_now("timeout: encoder did not finish all tables in time");
  end

  initial
  begin
    int t;
    int prev;
    lfsr_state = 32'h1f71;
    rst_n      = 1'b0;
    cl_val     = 1'b0;
    cl_last    = 1'b0;
    cl_len     = '0;
    out_stall  = 1'b0;
    stall_en   = 1'b0;
    repeat (4) @(posedge clk_gated);
    @(negedge clk_gated);
    rst_n = 1'b1;
    if (busy || seq_val || done)
      fail_now("busy, seq_val or done not low after reset");

    // distinct neighbours give literals only
    for (t = 0; t < 2; t++)
    begin
      cur_tbl.delete();
      prev = 0;
      repeat (40)
      begin
        prev = pick_nz(prev);
        add_run(prev, 1);
      end
      run_table(1'b0);
    end

    // zero runs where the first table hits the 138 split directly
    for (t = 0; t < 3; t++)
    begin
      cur_tbl.delete();
      if (t == 0)
      begin
        add_run(0, 138);
        add_run(5, 1);
        add_run(0, 300);
        add_run(9, 1);
      end
      while (cur_tbl.size() < 500)
      begin
        add_run(0, rand_range(1, 300));
        add_run(rand_range(1, 15), 1);
      end
      run_table(1'b0);
    end

    // nonzero repeat runs
    for (t = 0; t < 2; t++)
    begin
      cur_tbl.delete();
      prev = 0;
      while (cur_tbl.size() < 300)
      begin
        prev = pick_nz(prev);
        add_run(prev, rand_range(1, 20));
      end
      run_table(1'b0);
    end

    // mixed tables under random stall, back to back
    for (t = 0; t < 3; t++)
    begin
      cur_tbl.delete();
      while (cur_tbl.size() < 400)
      begin
        if (rand_bits(1) == 32'd1)
          add_run(0, rand_range(1, 150));
        else
          add_run(rand_range(1, 15), rand_range(1, 16));
      end
      run_table(1'b1);
    end

    repeat (4) drive_edge();
    if (busy || seq_val || done)
      fail_now("encoder did not return to idle after the last table");
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- bench/cl_rle_props.sv
`timescale 1ns/1ns
// bound checks on the encoder outputs
// stall hold, extra length per symbol, done width, busy in reset
module cl_rle_props
  import deflate_cl_pkg::*;
(
  input logic          clk_gated,
  input logic          rst_n,
  input logic          busy,
  input logic          seq_val,
  input logic          out_stall,
  input logic          done,
  input cl_sym_t       seq_sym,
  input cl_extra_t     seq_extra,
  input cl_extra_len_t seq_extra_len
);

  hold_on_stall: assert property (@(posedge clk_gated) disable iff (!rst_n)
    (seq_val && out_stall) |=> (seq_val && $stable(seq_sym) && $stable(seq_extra)
                                && $stable(seq_extra_len)))
    else $error("output changed while stalled");

  xlen_by_sym: assert property (@(posedge clk_gated) disable iff (!rst_n)
    seq_val |-> (seq_extra_len == ((seq_sym == 5'd16) ? 3'd2 :
                                   (seq_sym == 5'd17) ? 3'd3 :
                                   (seq_sym == 5'd18) ? 3'd7 : 3'd0)))
    else $error("extra length does not fit the symbol");

  done_pulse: assert property (@(posedge clk_gated) disable iff (!rst_n) done |=> !done)
    else $error("done held for more than one cycle");

  busy_in_reset: assert property (@(posedge clk_gated) !rst_n |-> !busy)
    else $error("busy high during reset");

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns
// free-running testbench clock, 40 ns period
module tb_clock
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;  // half period

endmodule

//--- src/cl_rle_top.sv
`timescale 1ns/1ns
// code-length run-length encoder top level
// FSM, run counter and symbol emitter
module cl_rle_top
  import deflate_cl_pkg::*;
  import cl_rle_ctrl_pkg::*;
(
  input  logic          clk_gated,
  input  logic          rst_n,
  input  logic          cl_val,
  input  logic          cl_last,
  input  logic          out_stall,
  input  cl_len_t       cl_len,
  output logic          busy,
  output logic          seq_val,
  output logic          done,
  output cl_sym_t       seq_sym,
  output cl_extra_t     seq_extra,
  output cl_extra_len_t seq_extra_len,
  output seq_cnt_t      seq_count,
  output xtr_total_t    extra_total
);

  logic     take;
  logic     flush_step;
  logic     clear;
  cl_len_t  run_val;
  run_cnt_t run_cnt;
  logic     head_pend;
  logic     run_full;
  logic     run_break;
  logic     run_empty;
  logic     last_seen;
  run_cnt_t emit_used;
  logic     out_free;

  cl_rle_fsm u_fsm (
    .clk_gated  (clk_gated),
    .rst_n      (rst_n),
    .cl_val     (cl_val),
    .run_full   (run_full),
    .run_break  (run_break),
    .run_empty  (run_empty),
    .head_pend  (head_pend),
    .last_seen  (last_seen),
    .out_free   (out_free),
    .busy       (busy),
    .take       (take),
    .flush_step (flush_step),
    .clear      (clear),
    .done       (done)
  );

  run_counter u_run (
    .clk_gated  (clk_gated),
    .rst_n      (rst_n),
    .take       (take),
    .flush_step (flush_step),
    .clear      (clear),
    .cl_len     (cl_len),
    .cl_last    (cl_last),
    .emit_used  (emit_used),
    .run_val    (run_val),
    .run_cnt    (run_cnt),
    .head_pend  (head_pend),
    .run_full   (run_full),
    .run_break  (run_break),
    .run_empty  (run_empty),
    .last_seen  (last_seen)
  );

  seq_emitter u_emit (
    .clk_gated     (clk_gated),
    .rst_n         (rst_n),
    .flush_step    (flush_step),
    .clear         (clear),
    .done          (done),
    .run_val       (run_val),
    .run_cnt       (run_cnt),
    .head_pend     (head_pend),
    .out_stall     (out_stall),
    .emit_used     (emit_used),
    .out_free      (out_free),
    .seq_val       (seq_val),
    .seq_sym       (seq_sym),
    .seq_extra     (seq_extra),
    .seq_extra_len (seq_extra_len),
    .seq_count     (seq_count),
    .extra_total   (extra_total)
  );

endmodule

//--- src/seq_emitter.sv
`timescale 1ns/1ns
// symbol selection for the pending run
// output register held under stall, symbol and extra-bit totals
module seq_emitter
  import deflate_cl_pkg::*;
  import cl_rle_ctrl_pkg::*;
(
  input  logic          clk_gated,
  input  logic          rst_n,
  input  logic          flush_step,
  input  logic          clear,
  input  logic          done,
  input  cl_len_t       run_val,
  input  run_cnt_t      run_cnt,
  input  logic          head_pend,
  input  logic          out_stall,
  output run_cnt_t      emit_used,
  output logic          out_free,
  output logic          seq_val,
  output cl_sym_t       seq_sym,
  output cl_extra_t     seq_extra,
  output cl_extra_len_t seq_extra_len,
  output seq_cnt_t      seq_count,
  output xtr_total_t    extra_total
);

  cl_sym_t       sym_c;
  cl_extra_t     extra_c;
  cl_extra_len_t extra_len_c;

  // register is free when empty or being taken this cycle
  assign out_free = !seq_val || !out_stall;

  always_comb
  begin
    sym_c       = {1'b0, run_val};  // literal by default
    extra_c     = '0;
    extra_len_c = '0;
    emit_used   = run_cnt_t'(1);
    if (head_pend)
      emit_used = '0;               // first occurrence is not a repeat
    else if (run_val == '0)
    begin
      if (run_cnt >= run_cnt_t'(ZR_RPT_HI_MIN))
      begin
        sym_c       = SYM_ZR_RPT_HI;
        extra_c     = cl_extra_t'(run_cnt - run_cnt_t'(ZR_RPT_HI_MIN));
        extra_len_c = XTR_ZR_HI_BITS;
        emit_used   = run_cnt;
      end
      else if (run_cnt >= run_cnt_t'(ZR_RPT_LO_MIN))
      begin
        sym_c       = SYM_ZR_RPT_LO;
        extra_c     = cl_extra_t'(run_cnt - run_cnt_t'(ZR_RPT_LO_MIN));
        extra_len_c = XTR_ZR_LO_BITS;
        emit_used   = run_cnt;
      end
    end
    else if (run_cnt >= run_cnt_t'(NZ_RPT_MIN))
    begin
      // count never passes 6 here, the run is flushed at that point
      sym_c       = SYM_NZ_RPT;
      extra_c     = cl_extra_t'(run_cnt - run_cnt_t'(NZ_RPT_MIN));
      extra_len_c = XTR_NZ_BITS;
      emit_used   = run_cnt;
    end
  end

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
      seq_val <= 1'b0;
    else if (flush_step)
      seq_val <= 1'b1;
    else if (!out_stall)
      seq_val <= 1'b0;
  end

  // only loaded when out_free, so a stalled symbol stays put
  always_ff @(posedge clk_gated)
  begin
    if (flush_step)
    begin
      seq_sym       <= sym_c;
      seq_extra     <= extra_c;
      seq_extra_len <= extra_len_c;
    end
  end

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      seq_count   <= '0;
      extra_total <= '0;
    end
    else if (clear && done)
    begin
      seq_count   <= '0;  // totals already reported
      extra_total <= '0;
    end
    else if (flush_step)
    begin
      seq_count   <= seq_count + 1'b1;
      extra_total <= extra_total + xtr_total_t'(extra_len_c);
    end
  end

endmodule

//--- src/run_counter.sv
`timescale 1ns/1ns
// run tracker for the length stream
// run value, repeat count, held break value and last flag
module run_counter
  import deflate_cl_pkg::*;
  import cl_rle_ctrl_pkg::*;
(
  input  logic     clk_gated,
  input  logic     rst_n,
  input  logic     take,
  input  logic     flush_step,
  input  logic     clear,
  input  cl_len_t  cl_len,
  input  logic     cl_last,
  input  run_cnt_t emit_used,
  output cl_len_t  run_val,
  output run_cnt_t run_cnt,
  output logic     head_pend,
  output logic     run_full,
  output logic     run_break,
  output logic     run_empty,
  output logic     last_seen
);

  logic     run_act;    // run_val holds a real value
  cl_len_t  brk_val;
  cl_len_t  new_val;
  run_cnt_t cnt_sub;
  logic     head_sub;
  logic     empty_nxt;
  logic     same_val;
  logic     start_run;

  // what is left of the run after this cycle's flush step
  always_comb
  begin
    cnt_sub  = run_cnt;
    head_sub = head_pend;
    if (flush_step)
    begin
      if (head_pend)
        head_sub = 1'b0;  // head literal always goes first
      else
        cnt_sub = run_cnt - emit_used;
    end
  end

  assign empty_nxt = (cnt_sub == '0) && !head_sub;
  assign same_val  = run_act && (cl_len == run_val);
  assign run_empty = (run_cnt == '0) && !head_pend;

  assign run_full = run_act && (run_cnt == ((run_val == '0) ? run_cnt_t'(ZR_RPT_MAX)
                                                            : run_cnt_t'(NZ_RPT_MAX)));

  // a new run starts from the input, or from the held value once drained
  assign start_run = (take && !same_val && (!run_act || empty_nxt)) ||
                     (run_break && run_empty);
  assign new_val   = take ? cl_len : brk_val;

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      run_act   <= 1'b0;
      run_val   <= '0;
      run_cnt   <= '0;
      head_pend <= 1'b0;
      run_break <= 1'b0;
      last_seen <= 1'b0;
    end
    else if (clear)
    begin
      run_act   <= 1'b0;
      run_val   <= '0;
      run_cnt   <= '0;
      head_pend <= 1'b0;
      run_break <= 1'b0;
      last_seen <= 1'b0;
    end
    else
    begin
      run_cnt   <= cnt_sub;
      head_pend <= head_sub;
      if (take && same_val)
        run_cnt <= cnt_sub + 1'b1;
      else if (start_run)
      begin
        run_act   <= 1'b1;
        run_val   <= new_val;
        run_cnt   <= run_cnt_t'(new_val == '0);  // zeros count the first one too
        head_pend <= (new_val != '0);
        run_break <= 1'b0;
      end
      else if (take)
        run_break <= 1'b1;  // different value while the run is still pending
      if (take && cl_last)
        last_seen <= 1'b1;
    end
  end

  always_ff @(posedge clk_gated)
  begin
    if (take && !same_val && !start_run)
      brk_val <= cl_len;
  end

endmodule

//--- src/cl_rle_fsm.sv
`timescale 1ns/1ns
// encoder sequencing FSM
// accept, flush and done steps, busy toward the length source
module cl_rle_fsm
  import cl_rle_ctrl_pkg::*;
(
  input  logic clk_gated,
  input  logic rst_n,
  input  logic cl_val,
  input  logic run_full,
  input  logic run_break,
  input  logic run_empty,
  input  logic head_pend,
  input  logic last_seen,
  input  logic out_free,
  output logic busy,
  output logic take,
  output logic flush_step,
  output logic clear,
  output logic done
);

  rle_state_t state;
  rle_state_t state_nxt;
  logic       run_hold;

  // run has to drain before another length is taken
  assign run_hold = run_full | run_break | last_seen;

  assign busy = (state == FLUSH) | (state == DONE) | ~out_free | run_hold;
  assign take = cl_val & ~busy;

  assign done  = (state == DONE);
  assign clear = (state == DONE);  // drops run and totals for the next table

  always_comb
  begin
    case (state)
      RUN:     flush_step = head_pend & out_free;  // head literal only
      FLUSH:   flush_step = ~run_empty & out_free;
      default: flush_step = 1'b0;
    endcase
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (take)
          state_nxt = RUN;
      RUN:
        if (run_hold)
          state_nxt = FLUSH;
      FLUSH:
        if (run_empty)
        begin
          if (run_break || !last_seen)
            state_nxt = RUN;    // held value reloads on this edge
          else if (out_free)
            state_nxt = DONE;   // last symbol leaves the output register
        end
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= state_nxt;
  end

endmodule

//--- src/cl_rle_ctrl_pkg.sv
// encoder control types
// FSM state enum, run count and output totals
package cl_rle_ctrl_pkg;

  typedef enum logic [1:0]
  {
    IDLE,
    RUN,
    FLUSH,
    DONE
  } rle_state_t;

  typedef logic [7:0]  run_cnt_t;    // holds up to 138 zeros
  typedef logic [9:0]  seq_cnt_t;    // symbols per table
  typedef logic [12:0] xtr_total_t;  // extra bits per table

endpackage

//--- src/deflate_cl_pkg.sv
// deflate code-length alphabet types
// repeat symbol codes, run thresholds and extra-bit widths
package deflate_cl_pkg;

  // one entry of the code-length table, 0..15
  typedef logic [3:0] cl_len_t;

  // code-length alphabet symbol, 0..18
  typedef logic [4:0] cl_sym_t;

  typedef logic [6:0] cl_extra_t;      // widest extra field is 7 bits
  typedef logic [2:0] cl_extra_len_t;

  // repeat symbols, literals 0..15 map to themselves
  localparam cl_sym_t SYM_NZ_RPT    = 5'd16;  // copy previous length
  localparam cl_sym_t SYM_ZR_RPT_LO = 5'd17;  // short zero run
  localparam cl_sym_t SYM_ZR_RPT_HI = 5'd18;  // long zero run

  // nonzero repeat group sizes for symbol 16
  localparam int unsigned NZ_RPT_MIN = 3;
  localparam int unsigned NZ_RPT_MAX = 6;

  // zero run sizes
  localparam int unsigned ZR_RPT_LO_MIN = 3;    // 17 covers 3..10
  localparam int unsigned ZR_RPT_HI_MIN = 11;   // 18 covers 11..138
  localparam int unsigned ZR_RPT_MAX    = 138;

  // extra bits after each repeat symbol
  localparam cl_extra_len_t XTR_NZ_BITS    = 3'd2;
  localparam cl_extra_len_t XTR_ZR_LO_BITS = 3'd3;
  localparam cl_extra_len_t XTR_ZR_HI_BITS = 3'd7;

endpackage
